/* source/core_pkg.sv */
package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int INSTR_W    = 16;
    localparam int OPCODE_W   = 4;
    localparam int REG_IDX_W  = 3;
    localparam int IMM_W      = 6;
    localparam int NUM_REGS   = 2 ** REG_IDX_W;   // Eight architectural registers

    localparam int OPCODE_LSB = 12;                // Bits 15..12
    localparam int RD_LSB     = 9;                 // Bits 11..9
    localparam int RS1_LSB    = 6;                 // Bits 8..6
    localparam int RS2_LSB    = 3;                 // Bits 5..3 shared with imm6
    localparam int IMM_LSB    = 0;                 // Bits 5..0

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Codes 8 to 15 are not assigned and decode as a nop
    typedef enum logic [OPCODE_W-1:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_addi = 4'h6,   // rs1 plus sign-extended imm6
        op_li   = 4'h7    // Sign-extended imm6 only
    } opcode_t;

endpackage

/* source/trace_pkg.sv */
package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline timing seen by the retire tracer
    ////////////////////////////////////////////////////////////////////////////

    // Edges from accept to retire without stall
    // decode, execute and result each add one
    localparam int PIPE_DEPTH = 3;

    // Smallest power of two that holds a full pipeline of entries
    localparam int MIN_QUEUE_DEPTH = 2 ** $clog2(PIPE_DEPTH);

endpackage

/* source/instr_decode.sv */
module instr_decode
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    input  logic               stall,
    input  logic               flush,
    output logic               accept,
    output logic               dec_valid,
    output opcode_t            dec_op,
    output reg_idx_t           dec_rd,
    output reg_idx_t           rs1_addr,
    output reg_idx_t           rs2_addr,
    output logic [IMM_W-1:0]   dec_imm,
    output logic               dec_use_imm
);

    logic [OPCODE_W-1:0] op_bits;      // Raw opcode field
    opcode_t             op_legal;     // Unassigned codes folded to nop
    logic                use_imm;

    ////////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////////

    assign op_bits = instr[OPCODE_LSB +: OPCODE_W];

    always_comb begin
        case (op_bits)
            op_add, op_sub, op_and, op_or, op_xor, op_addi, op_li: begin
                op_legal = opcode_t'(op_bits);
            end
            default: begin
                op_legal = op_nop;             // Reserved codes
            end
        endcase
    end

    // Second operand comes from imm6 instead of rs2
    assign use_imm = (op_legal == op_addi) || (op_legal == op_li);

    // No new work enters while the pipe is frozen or being cleared
    assign accept = instr_valid && !stall && !flush;

    ////////////////////////////////////////////////////////////////////////////
    // Decode stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;                 // Kill decode slot
        end else if (!stall) begin
            dec_valid <= instr_valid;          // Bubble when nothing offered
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op      <= op_legal;
            dec_rd      <= instr[RD_LSB +: REG_IDX_W];
            rs1_addr    <= instr[RS1_LSB +: REG_IDX_W];
            rs2_addr    <= instr[RS2_LSB +: REG_IDX_W];
            dec_imm     <= instr[IMM_LSB +: IMM_W];
            dec_use_imm <= use_imm;
        end
    end

endmodule

/* source/alu_execute.sv */
module alu_execute
    import core_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              dec_valid,
    input  opcode_t           dec_op,
    input  reg_idx_t          dec_rd,
    input  logic [IMM_W-1:0]  dec_imm,
    input  logic              dec_use_imm,
    input  logic [DATA_W-1:0] rs1_data,     // Already forwarded
    input  logic [DATA_W-1:0] rs2_data,     // Already forwarded
    output logic              ex_valid,
    output reg_idx_t          ex_rd,
    output logic [DATA_W-1:0] ex_data
);

    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] opnd_b;
    logic [DATA_W-1:0] alu_res;
    reg_idx_t          rd_next;

    ////////////////////////////////////////////////////////////////////////////
    // Operand select and ALU
    ////////////////////////////////////////////////////////////////////////////

    assign imm_ext = {{(DATA_W-IMM_W){dec_imm[IMM_W-1]}}, dec_imm};
    assign opnd_b  = dec_use_imm ? imm_ext : rs2_data;

    // All arithmetic wraps at DATA_W
    always_comb begin
        alu_res = '0;
        rd_next = dec_rd;
        case (dec_op)
            op_add, op_addi: alu_res = rs1_data + opnd_b;
            op_sub:          alu_res = rs1_data - opnd_b;
            op_and:          alu_res = rs1_data & opnd_b;
            op_or:           alu_res = rs1_data | opnd_b;
            op_xor:          alu_res = rs1_data ^ opnd_b;
            op_li:           alu_res = opnd_b;     // Immediate path selected
            default: begin
                alu_res = '0;                      // Nop writes zero to r0
                rd_next = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;                      // Kill execute slot
        end else if (!stall) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            ex_rd   <= rd_next;
            ex_data <= alu_res;
        end
    end

endmodule

/* source/result_writeback.sv */
module result_writeback
    import core_pkg::*;
#(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              ex_valid,
    input  reg_idx_t          ex_rd,
    input  logic [DATA_W-1:0] ex_data,
    input  reg_idx_t          rs1_addr,
    input  reg_idx_t          rs2_addr,
    output logic [DATA_W-1:0] rs1_data,
    output logic [DATA_W-1:0] rs2_data,
    output logic              retire_now,    // Write enable this cycle
    output logic              retire_valid,
    output reg_idx_t          retire_rd,
    output logic [DATA_W-1:0] retire_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Result stage commits unless frozen or killed
    assign retire_now = ex_valid && !stall && !flush;

    ////////////////////////////////////////////////////////////////////////////
    // Register file with bypass of the pending write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_now && (ex_rd != '0)) begin
            regs[ex_rd] <= ex_data;                // r0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0)                    ? '0      :
                      (ex_valid && (ex_rd == rs1_addr))   ? ex_data :
                                                            regs[rs1_addr];

    assign rs2_data = (rs2_addr == '0)                    ? '0      :
                      (ex_valid && (ex_rd == rs2_addr))   ? ex_data :
                                                            regs[rs2_addr];

    ////////////////////////////////////////////////////////////////////////////
    // Retire report
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= retire_now;            // Single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (retire_now) begin
            retire_rd   <= ex_rd;
            retire_data <= ex_data;                // Reported even for r0
        end
    end

endmodule

/* source/pipeline_trace.sv */
module pipeline_trace
    import trace_pkg::*;
#(
    parameter int CYCLE_W     = 16,
    parameter int SEQ_W       = 8,
    parameter int TRACE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  logic               retire_now,     // Pop the oldest entry
    input  logic               flush,
    output logic               trace_valid,
    output logic [SEQ_W-1:0]   trace_seq,
    output logic [CYCLE_W-1:0] trace_issue_cycle,
    output logic [CYCLE_W-1:0] trace_latency
);

    // Never smaller than what the pipeline can hold in flight
    localparam int Q_DEPTH = (TRACE_DEPTH < PIPE_DEPTH) ? MIN_QUEUE_DEPTH : TRACE_DEPTH;
    localparam int PTR_W   = $clog2(Q_DEPTH);

    logic [SEQ_W-1:0]   seq_mem [Q_DEPTH];     // Sequence number per entry
    logic [CYCLE_W-1:0] cyc_mem [Q_DEPTH];     // Accept cycle per entry

    logic [PTR_W-1:0]   head_ptr;
    logic [PTR_W-1:0]   tail_ptr;
    logic [CYCLE_W-1:0] cycle_cnt;
    logic [SEQ_W-1:0]   next_seq;
    logic [CYCLE_W-1:0] retire_cycle;

    ////////////////////////////////////////////////////////////////////////////
    // Free-running cycle and sequence counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
            next_seq  <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;     // Counts through stalls
            if (accept) begin
                next_seq <= next_seq + 1'b1;   // Wraps at SEQ_W
            end
        end
    end

    // The trace record shows up in the cycle after the retire edge
    assign retire_cycle = cycle_cnt + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // In-flight queue
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else if (flush) begin
            head_ptr <= tail_ptr;              // Everything queued is killed
        end else begin
            if (accept) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (retire_now) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            seq_mem[tail_ptr] <= next_seq;
            cyc_mem[tail_ptr] <= cycle_cnt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Trace record
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= retire_now;         // Lines up with retire_valid
        end
    end

    always_ff @(posedge clk) begin
        if (retire_now) begin
            trace_seq         <= seq_mem[head_ptr];
            trace_issue_cycle <= cyc_mem[head_ptr];
            trace_latency     <= retire_cycle - cyc_mem[head_ptr];
        end
    end

endmodule

/* source/pipe_core_top.sv */
module pipe_core_top
    import core_pkg::*;
#(
    parameter int DATA_W      = 16,
    parameter int CYCLE_W     = 16,
    parameter int SEQ_W       = 8,
    parameter int TRACE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  logic [INSTR_W-1:0] instr,
    input  logic               stall,
    input  logic               flush,
    output logic               retire_valid,
    output reg_idx_t           retire_rd,
    output logic [DATA_W-1:0]  retire_data,
    output logic               trace_valid,
    output logic [SEQ_W-1:0]   trace_seq,
    output logic [CYCLE_W-1:0] trace_issue_cycle,
    output logic [CYCLE_W-1:0] trace_latency
);

    // Decode stage
    logic              accept;
    logic              dec_valid;
    opcode_t           dec_op;
    reg_idx_t          dec_rd;
    reg_idx_t          rs1_addr;
    reg_idx_t          rs2_addr;
    logic [IMM_W-1:0]  dec_imm;
    logic              dec_use_imm;

    // Execute stage and operand reads
    logic [DATA_W-1:0] rs1_data;
    logic [DATA_W-1:0] rs2_data;
    logic              ex_valid;
    reg_idx_t          ex_rd;
    logic [DATA_W-1:0] ex_data;
    logic              retire_now;

    instr_decode u_decode (
        .clk, .rst, .instr_valid, .instr, .stall, .flush,
        .accept, .dec_valid, .dec_op, .dec_rd, .rs1_addr, .rs2_addr,
        .dec_imm, .dec_use_imm
    );

    alu_execute #(.DATA_W(DATA_W)) u_execute (
        .clk, .rst, .stall, .flush, .dec_valid, .dec_op, .dec_rd,
        .dec_imm, .dec_use_imm, .rs1_data, .rs2_data,
        .ex_valid, .ex_rd, .ex_data
    );

    result_writeback #(.DATA_W(DATA_W)) u_result (
        .clk, .rst, .stall, .flush, .ex_valid, .ex_rd, .ex_data,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .retire_now, .retire_valid, .retire_rd, .retire_data
    );

    pipeline_trace #(
        .CYCLE_W    (CYCLE_W),
        .SEQ_W      (SEQ_W),
        .TRACE_DEPTH(TRACE_DEPTH)
    ) u_trace (
        .clk, .rst, .accept, .retire_now, .flush,
        .trace_valid, .trace_seq, .trace_issue_cycle, .trace_latency
    );

endmodule

/* testbench/tb_pipe_core.sv */
module tb_pipe_core
    import core_pkg::*;
    import trace_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W     = 16;
    localparam int CYCLE_W    = 16;
    localparam int SEQ_W      = 8;
    localparam int N_INSTR    = 2000;
    localparam int MAX_CYCLES = 20000;    // Stimulus loop limit
    localparam int DRAIN_MAX  = 40;

    // One in-flight instruction as the model sees it
    typedef struct packed {
        reg_idx_t                        rd;
        logic [DATA_W-1:0]               data;
        logic [SEQ_W-1:0]                seq;
        logic [CYCLE_W-1:0]              cyc;
        logic [CYCLE_W-1:0]              stalls;
        logic [3:0]                      stage;
        logic [NUM_REGS-1:0][DATA_W-1:0] snap;  // Registers before this one wrote
    } entry_t;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    logic [15:0]        instr;
    logic               stall;
    logic               flush;
    logic               retire_valid;
    reg_idx_t           retire_rd;
    logic [DATA_W-1:0]  retire_data;
    logic               trace_valid;
    logic [SEQ_W-1:0]   trace_seq;
    logic [CYCLE_W-1:0] trace_issue_cycle;
    logic [CYCLE_W-1:0] trace_latency;

    // Reference model state
    entry_t                          exp_q[$];
    logic [NUM_REGS-1:0][DATA_W-1:0] spec_regs;
    logic [CYCLE_W-1:0]              model_cycle;
    logic [SEQ_W-1:0]                model_seq;
    logic [DATA_W-1:0]               commit_regs [NUM_REGS] = '{default: '0};
    logic                            exp_retire_valid = 1'b0;
    reg_idx_t                        exp_retire_rd;
    logic [DATA_W-1:0]               exp_retire_data;
    logic [SEQ_W-1:0]                exp_trace_seq;
    logic [CYCLE_W-1:0]              exp_issue_cycle;
    logic [CYCLE_W-1:0]              exp_latency;
    logic                            prev_stall = 1'b0;
    logic                            prev_flush = 1'b0;

    // Stimulus state
    logic [31:0] lfsr_state = 32'hc051_d95f;
    reg_idx_t    recent_rd [3] = '{default: '0};

    pipe_core_top #(
        .DATA_W     (DATA_W),
        .CYCLE_W    (CYCLE_W),
        .SEQ_W      (SEQ_W),
        .TRACE_DEPTH(4)
    ) UUT (
        .clk, .rst, .instr_valid, .instr, .stall, .flush,
        .retire_valid, .retire_rd, .retire_data,
        .trace_valid, .trace_seq, .trace_issue_cycle, .trace_latency
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("ERR %s expected %0h actual %0h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_text(input string what);
        $display("%s", what);
        abort_run();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;                 // Taps 32, 22, 2, 1
        end
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Mostly recent destinations so that distances 1 to 3 come up often
    function automatic reg_idx_t pick_source();
        logic [1:0] sel;
        sel = 2'(take_bits(2));
        if (sel == 2'd0) begin
            return 3'(take_bits(3));
        end
        return recent_rd[sel - 2'd1];
    endfunction

    task automatic build_instr(output logic [15:0] word);
        logic [3:0] op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        op = 4'(take_bits(3));
        if (take_bits(3) == 0) begin
            op[3] = 1'b1;                           // Reserved code now and then
        end
        rd  = 3'(take_bits(3));
        rs1 = pick_source();
        if (op == op_addi || op == op_li) begin
            word = {op, rd, rs1, 6'(take_bits(6))};
        end else begin
            word = {op, rd, rs1, pick_source(), 3'(take_bits(3))};
        end
    endtask

    function automatic logic writes_rd(input logic [3:0] op);
        return (op != 4'h0) && (op[3] == 1'b0);
    endfunction

    function automatic logic [DATA_W-1:0] expected_value(input logic [3:0] op,
            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
            input logic [IMM_W-1:0] imm);
        logic [DATA_W-1:0] simm;
        simm = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_addi: return a + simm;
            op_li:   return simm;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model, one step per clock edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        entry_t   ent;
        logic [3:0] op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        if (rst) begin
            exp_q.delete();
            spec_regs   = '0;
            model_cycle = '0;
            model_seq   = '0;
            exp_retire_valid <= 1'b0;
            prev_stall       <= 1'b0;
            prev_flush       <= 1'b0;
            for (int k = 0; k < NUM_REGS; k++) begin
                commit_regs[k] <= '0;
            end
        end else begin
            exp_retire_valid <= 1'b0;
            prev_stall       <= stall;
            prev_flush       <= flush;
            if (flush) begin
                if (exp_q.size() != 0) begin
                    ent       = exp_q[0];
                    spec_regs = ent.snap;           // Back to oldest killed entry
                end
                exp_q.delete();
            end else if (stall) begin
                for (int i = 0; i < exp_q.size(); i++) begin
                    ent        = exp_q[i];
                    ent.stalls = ent.stalls + 16'd1;
                    exp_q[i]   = ent;
                end
            end else begin
                for (int i = 0; i < exp_q.size(); i++) begin
                    ent       = exp_q[i];
                    ent.stage = ent.stage + 4'd1;
                    exp_q[i]  = ent;
                end
                if (exp_q.size() != 0 && exp_q[0].stage == 4'(PIPE_DEPTH)) begin
                    ent = exp_q.pop_front();
                    exp_retire_valid <= 1'b1;
                    exp_retire_rd    <= ent.rd;
                    exp_retire_data  <= ent.data;
                    exp_trace_seq    <= ent.seq;
                    exp_issue_cycle  <= ent.cyc;
                    exp_latency      <= CYCLE_W'(PIPE_DEPTH) + ent.stalls;
                    if (ent.rd != '0) begin
                        commit_regs[ent.rd] <= ent.data;
                    end
                end
                if (instr_valid) begin
                    op         = instr[15:12];
                    rs1        = instr[8:6];
                    rs2        = instr[5:3];
                    ent.rd     = writes_rd(op) ? instr[11:9] : 3'd0;
                    ent.data   = expected_value(op, spec_regs[rs1], spec_regs[rs2],
                                                instr[5:0]);
                    ent.seq    = model_seq;
                    ent.cyc    = model_cycle;
                    ent.stalls = '0;
                    ent.stage  = 4'd1;
                    ent.snap   = spec_regs;
                    exp_q.push_back(ent);
                    if (ent.rd != '0) begin
                        spec_regs[ent.rd] = ent.data;
                    end
                    model_seq = model_seq + 8'd1;
                end
            end
            model_cycle = model_cycle + 16'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_retire_valid: assert property (@(posedge clk) retire_valid == exp_retire_valid)
        else report_value("retire_valid", 32'($sampled(exp_retire_valid)),
                          32'($sampled(retire_valid)));
    a_trace_valid: assert property (@(posedge clk) trace_valid == exp_retire_valid)
        else report_value("trace_valid", 32'($sampled(exp_retire_valid)),
                          32'($sampled(trace_valid)));
    a_retire_rd: assert property (@(posedge clk) retire_valid |-> retire_rd == exp_retire_rd)
        else report_value("retire_rd", 32'($sampled(exp_retire_rd)),
                          32'($sampled(retire_rd)));
    a_retire_data: assert property (@(posedge clk)
            retire_valid |-> retire_data == exp_retire_data)
        else report_value("retire_data", 32'($sampled(exp_retire_data)),
                          32'($sampled(retire_data)));
    a_trace_seq: assert property (@(posedge clk) trace_valid |-> trace_seq == exp_trace_seq)
        else report_value("trace_seq", 32'($sampled(exp_trace_seq)),
                          32'($sampled(trace_seq)));
    a_issue_cycle: assert property (@(posedge clk)
            trace_valid |-> trace_issue_cycle == exp_issue_cycle)
        else report_value("trace_issue_cycle", 32'($sampled(exp_issue_cycle)),
                          32'($sampled(trace_issue_cycle)));
    a_latency: assert property (@(posedge clk) trace_valid |-> trace_latency == exp_latency)
        else report_value("trace_latency", 32'($sampled(exp_latency)),
                          32'($sampled(trace_latency)));
    a_stall_quiet: assert property (@(posedge clk) prev_stall |-> !retire_valid && !trace_valid)
        else report_text("retire or trace pulse following a stall edge");
    a_flush_quiet: assert property (@(posedge clk) prev_flush |-> !retire_valid && !trace_valid)
        else report_text("killed instruction retired after a flush edge");

    // Architectural state against retired results only
    for (genvar k = 0; k < NUM_REGS; k++) begin : g_reg_check
        a_reg: assert property (@(posedge clk) UUT.u_result.regs[k] == commit_regs[k])
            else report_value($sformatf("register r%0d", k), 32'($sampled(commit_regs[k])),
                              32'($sampled(UUT.u_result.regs[k])));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          issued;
        int          cycles;
        int          stall_left;
        int          waited;
        logic        stall_v;
        logic        flush_v;
        logic        valid_v;
        logic [15:0] word;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        issued      = 0;
        cycles      = 0;
        stall_left  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (issued < N_INSTR && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
            if (stall_left > 0) begin
                stall_v = 1'b1;
                stall_left--;
            end else if (take_bits(4) == 0) begin
                stall_v    = 1'b1;                  // Burst of 1 to 4 cycles
                stall_left = int'(take_bits(2));
            end else begin
                stall_v = 1'b0;
            end
            flush_v = !stall_v && (take_bits(6) == 0);
            valid_v = take_bits(2) != 0;
            build_instr(word);
            stall       <= stall_v;
            flush       <= flush_v;
            instr_valid <= valid_v;
            instr       <= word;
            if (valid_v && !stall_v && !flush_v) begin
                issued++;
                recent_rd[2] = recent_rd[1];
                recent_rd[1] = recent_rd[0];
                recent_rd[0] = word[11:9];
            end
        end
        if (issued < N_INSTR) begin
            report_text("stimulus loop ran out of cycles before all instructions issued");
        end else begin
            @(posedge clk);
            stall       <= 1'b0;
            flush       <= 1'b0;
            instr_valid <= 1'b0;
            waited = 0;
            while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
                @(posedge clk);
                waited++;
            end
            if (exp_q.size() != 0) begin
                report_text("pipeline did not drain after the last instruction");
            end else begin
                repeat (3) @(posedge clk);          // Let the last retire be checked
                $display("TEST PASSED");
                $finish;
            end
        end
    end

endmodule

/* compile.f */
source/core_pkg.sv
source/trace_pkg.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/pipeline_trace.sv
source/pipe_core_top.sv
testbench/tb_pipe_core.sv

/* Makefile */
TOP := tb_pipe_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir
